/* filelist.f */
rtl/chess_view_pkg.sv
rtl/board_regs.sv
rtl/frame_sequencer.sv
rtl/square_painter.sv
rtl/pixel_out.sv
rtl/chess_view_top.sv
verification/tb_chess_view.sv

/* rtl/board_regs.sv */
`timescale 1ns/1ns

module board_regs (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [7:0]                  paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [31:0]                 pwdata,
  input  logic [2:0]                  sq_col,
  input  logic [2:0]                  sq_row,
  input  logic                        busy,
  input  logic [7:0]                  frame_count,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        start,
  output chess_view_pkg::piece_code_u sq_code,
  output logic [2:0]                  box_x,
  output logic [2:0]                  box_y
);
  import chess_view_pkg::*;

  // one word per board row, column c in nibble c
  logic [31:0] rows [8];
  logic [31:0] sq_word;
  logic        wr_en;
  logic        row_hit;

  assign wr_en = psel && penable && pwrite;
  assign row_hit = paddr >= REG_ROW0 && paddr < REG_BOX;
  assign pready = 1'b1;
  assign pslverr = psel && penable && (paddr > REG_STATUS);

  // square lookup for the sequencer
  assign sq_word = rows[sq_row];
  assign sq_code.raw = sq_word[4*sq_col +: 4];

  always_ff @(posedge clk) begin
    if (wr_en && row_hit) begin
      rows[paddr[4:2]] <= pwdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      box_x <= 3'd0;
      box_y <= 3'd0;
      start <= 1'b0;
    end else begin
      // one cycle pulse per write of ctrl bit 0
      start <= wr_en && (paddr == REG_CTRL) && pwdata[0];
      if (wr_en && paddr == REG_BOX) begin
        box_x <= pwdata[2:0];
        box_y <= pwdata[6:4];
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (row_hit) begin
      prdata = rows[paddr[4:2]];
    end else begin
      case (paddr)
        REG_BOX:    prdata = {25'd0, box_y, 1'b0, box_x};
        REG_STATUS: prdata = {16'd0, frame_count, 7'd0, busy};
        default:    prdata = '0;
      endcase
    end
  end

  // access phase always follows a setup phase
  a_apb_setup: assert property (@(posedge clk) disable iff (reset)
    penable |-> $past(psel));

endmodule

/* rtl/chess_view_pkg.sv */
package chess_view_pkg;

  // pixel coordinate and colour widths
  localparam int COORD_W = 8;
  localparam int COLOUR_W = 3;

  // colour codes on the pixel port
  localparam logic [COLOUR_W-1:0] COL_DARK = 3'd0;
  localparam logic [COLOUR_W-1:0] COL_LIGHT = 3'd1;
  localparam logic [COLOUR_W-1:0] COL_WHITE = 3'd2;
  localparam logic [COLOUR_W-1:0] COL_BLACK = 3'd3;
  localparam logic [COLOUR_W-1:0] COL_BOX = 3'd4;

  // piece kinds, 1 to 6 are pawn, knight, bishop, rook, queen, king
  localparam logic [2:0] KIND_EMPTY = 3'd0;
  localparam logic [2:0] KIND_RESERVED = 3'd7;

  // one square code, kept raw in the registers and split when drawn
  typedef union packed {
    logic [3:0] raw;
    struct packed {
      logic       black;
      logic [2:0] kind;
    } f;
  } piece_code_u;

  // APB register map
  localparam logic [7:0] REG_ROW0 = 8'h00;
  localparam logic [7:0] REG_BOX = 8'h20;
  localparam logic [7:0] REG_CTRL = 8'h24;
  localparam logic [7:0] REG_STATUS = 8'h28;

endpackage

/* rtl/chess_view_top.sv */
`timescale 1ns/1ns

module chess_view_top #(
  parameter int SCALE_LOG2 = 0,
  parameter int BLINK_FRAMES = 2
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [7:0]                          paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                pix_valid,
  input  logic                                pix_ready,
  output logic [chess_view_pkg::COORD_W-1:0]  pix_x,
  output logic [chess_view_pkg::COORD_W-1:0]  pix_y,
  output logic [chess_view_pkg::COLOUR_W-1:0] pix_colour,
  output logic                                frame_done
);
  import chess_view_pkg::*;

  logic                start;
  logic                busy;
  logic [7:0]          frame_count;
  logic [2:0]          sq_col;
  logic [2:0]          sq_row;
  piece_code_u         sq_code;
  logic [2:0]          box_x;
  logic [2:0]          box_y;
  logic                job_start;
  logic [2:0]          job_col;
  logic [2:0]          job_row;
  piece_code_u         job_code;
  logic                job_box;
  logic                job_last;
  logic                job_done;
  logic                push;
  logic                full;
  logic [COORD_W-1:0]  push_x;
  logic [COORD_W-1:0]  push_y;
  logic [COLOUR_W-1:0] push_colour;
  logic                push_last;

  // host side
  board_regs i_regs (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .sq_col, .sq_row, .busy, .frame_count,
    .prdata, .pready, .pslverr, .start, .sq_code, .box_x, .box_y
  );

  frame_sequencer #(.SCALE_LOG2(SCALE_LOG2), .BLINK_FRAMES(BLINK_FRAMES)) i_seq (
    .clk, .reset, .start, .sq_code, .box_x, .box_y, .job_done, .frame_done,
    .sq_col, .sq_row, .job_start, .job_col, .job_row, .job_code,
    .job_box, .job_last, .busy, .frame_count
  );

  square_painter #(.SCALE_LOG2(SCALE_LOG2)) i_painter (
    .clk, .reset, .job_start, .job_col, .job_row, .job_code, .job_box,
    .job_last, .full, .job_done, .push, .push_x, .push_y, .push_colour, .push_last
  );

  // frame-buffer side
  pixel_out i_out (
    .clk, .reset, .push, .push_x, .push_y, .push_colour, .push_last, .pix_ready,
    .full, .pix_valid, .pix_x, .pix_y, .pix_colour, .frame_done
  );

endmodule

/* rtl/frame_sequencer.sv */
`timescale 1ns/1ns

module frame_sequencer #(
  parameter int SCALE_LOG2 = 0,
  parameter int BLINK_FRAMES = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  chess_view_pkg::piece_code_u sq_code,
  input  logic [2:0]                  box_x,
  input  logic [2:0]                  box_y,
  input  logic                        job_done,
  input  logic                        frame_done,
  output logic [2:0]                  sq_col,
  output logic [2:0]                  sq_row,
  output logic                        job_start,
  output logic [2:0]                  job_col,
  output logic [2:0]                  job_row,
  output chess_view_pkg::piece_code_u job_code,
  output logic                        job_box,
  output logic                        job_last,
  output logic                        busy,
  output logic [7:0]                  frame_count
);
  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_ISSUE_SQ = 3'd1;
  localparam logic [2:0] ST_ADVANCE = 3'd2;
  localparam logic [2:0] ST_WAIT_SQ = 3'd3;
  localparam logic [2:0] ST_ISSUE_BOX = 3'd4;
  localparam logic [2:0] ST_WAIT_BOX = 3'd5;
  localparam logic [2:0] ST_WAIT_DONE = 3'd6;
  localparam int PH_W = $clog2(BLINK_FRAMES + 1);
  // pixels in one square job
  localparam int SQ_PIX = 64 << (2 * SCALE_LOG2);

  logic [2:0]      state;
  logic [5:0]      sq_idx;
  logic            sq_last;
  logic            blink_on;
  logic [PH_W-1:0] phase_cnt;
  logic            job_open;
  logic [15:0]     job_cycles;

  assign sq_col = sq_idx[2:0];
  assign sq_row = sq_idx[5:3];
  assign busy = state != ST_IDLE;
  assign job_start = (state == ST_ISSUE_SQ) || (state == ST_ISSUE_BOX);
  assign job_box = state == ST_ISSUE_BOX;
  assign job_col = job_box ? box_x : sq_idx[2:0];
  assign job_row = job_box ? box_y : sq_idx[5:3];
  assign job_code = sq_code;
  // box job ends the frame, or the last square when the box is off
  assign job_last = job_box || (sq_idx == 6'd63 && !blink_on);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      sq_idx <= 6'd0;
      sq_last <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (start) state <= ST_ISSUE_SQ;
        ST_ISSUE_SQ: state <= ST_ADVANCE;
        ST_ADVANCE: begin
          // step while the painter works, wraps to 0 after the last square
          sq_last <= sq_idx == 6'd63;
          sq_idx <= sq_idx + 6'd1;
          state <= ST_WAIT_SQ;
        end
        ST_WAIT_SQ: begin
          if (job_done) begin
            if (!sq_last) state <= ST_ISSUE_SQ;
            else if (blink_on) state <= ST_ISSUE_BOX;
            else state <= ST_WAIT_DONE;
          end
        end
        ST_ISSUE_BOX: state <= ST_WAIT_BOX;
        ST_WAIT_BOX: if (job_done) state <= ST_WAIT_DONE;
        ST_WAIT_DONE: if (frame_done) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // frame count and blink phase
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_count <= 8'd0;
      phase_cnt <= '0;
      blink_on <= 1'b0;
    end else if (frame_done) begin
      frame_count <= frame_count + 8'd1;
      if (phase_cnt == PH_W'(BLINK_FRAMES - 1)) begin
        phase_cnt <= '0;
        blink_on <= !blink_on;
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
    end
  end

  // outstanding job tracking for the checks below
  always_ff @(posedge clk) begin
    if (reset) begin
      job_open <= 1'b0;
      job_cycles <= 16'd0;
    end else if (job_start) begin
      job_open <= 1'b1;
      job_cycles <= 16'd0;
    end else begin
      if (job_done) job_open <= 1'b0;
      if (job_cycles != 16'hffff) job_cycles <= job_cycles + 16'd1;
    end
  end

  a_one_job: assert property (@(posedge clk) disable iff (reset)
    job_start |-> !job_open);

  // a square job cannot finish before all its pixels went out
  a_job_len: assert property (@(posedge clk) disable iff (reset)
    job_done |-> job_open && (state == ST_WAIT_BOX || job_cycles >= SQ_PIX));

endmodule

/* rtl/pixel_out.sv */
`timescale 1ns/1ns

module pixel_out (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                push,
  input  logic [chess_view_pkg::COORD_W-1:0]  push_x,
  input  logic [chess_view_pkg::COORD_W-1:0]  push_y,
  input  logic [chess_view_pkg::COLOUR_W-1:0] push_colour,
  input  logic                                push_last,
  input  logic                                pix_ready,
  output logic                                full,
  output logic                                pix_valid,
  output logic [chess_view_pkg::COORD_W-1:0]  pix_x,
  output logic [chess_view_pkg::COORD_W-1:0]  pix_y,
  output logic [chess_view_pkg::COLOUR_W-1:0] pix_colour,
  output logic                                frame_done
);
  import chess_view_pkg::*;

  logic [COORD_W-1:0]  fifo_x [2];
  logic [COORD_W-1:0]  fifo_y [2];
  logic [COLOUR_W-1:0] fifo_c [2];
  logic                fifo_l [2];
  logic                wr_ptr;
  logic                rd_ptr;
  logic [1:0]          count;
  logic                pop;

  assign pop = pix_valid && pix_ready;
  assign full = count == 2'd2;
  assign pix_valid = count != 2'd0;
  // head entry only moves on a transfer, so a stall holds it
  assign pix_x = fifo_x[rd_ptr];
  assign pix_y = fifo_y[rd_ptr];
  assign pix_colour = fifo_c[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_x[wr_ptr] <= push_x;
      fifo_y[wr_ptr] <= push_y;
      fifo_c[wr_ptr] <= push_colour;
      fifo_l[wr_ptr] <= push_last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count <= 2'd0;
      frame_done <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr ^ push;
      rd_ptr <= rd_ptr ^ pop;
      count <= count + 2'(push) - 2'(pop);
      frame_done <= pop && fifo_l[rd_ptr];
    end
  end

  a_stall_hold: assert property (@(posedge clk) disable iff (reset)
    pix_valid && !pix_ready |=> pix_valid && $stable({pix_x, pix_y, pix_colour}));

  // painter must respect the full flag
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !full);

endmodule

/* rtl/square_painter.sv */
`timescale 1ns/1ns

module square_painter #(
  parameter int SCALE_LOG2 = 0
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  job_start,
  input  logic [2:0]                            job_col,
  input  logic [2:0]                            job_row,
  input  chess_view_pkg::piece_code_u           job_code,
  input  logic                                  job_box,
  input  logic                                  job_last,
  input  logic                                  full,
  output logic                                  job_done,
  output logic                                  push,
  output logic [chess_view_pkg::COORD_W-1:0]    push_x,
  output logic [chess_view_pkg::COORD_W-1:0]    push_y,
  output logic [chess_view_pkg::COLOUR_W-1:0]   push_colour,
  output logic                                  push_last
);
  import chess_view_pkg::*;

  // square side is 1 << SQ_W pixels
  localparam int SQ_W = 3 + SCALE_LOG2;
  localparam logic [SQ_W:0] SQ_MAX = {1'b0, {SQ_W{1'b1}}};

  // sprite rows addressed by {kind, row}, kinds 0 and 7 have no bitmap
  logic [7:0]          sprite_rom [0:63];
  logic [2:0]          j_col;
  logic [2:0]          j_row;
  piece_code_u         j_code;
  logic                j_box;
  logic                j_last;
  logic                active;
  logic [SQ_W:0]       u;
  logic [SQ_W:0]       v;
  logic                go;
  logic                at_end;
  logic                at_border;
  logic                s1_valid;
  logic                s1_end;
  logic [SQ_W-1:0]     s1_u;
  logic [SQ_W-1:0]     s1_v;
  logic [7:0]          s1_bits;
  logic                s2_valid;
  logic                s2_end;
  logic                is_piece;
  logic                sprite_on;
  logic [COLOUR_W-1:0] sq_colour;
  logic [COLOUR_W-1:0] colour_next;

  initial $readmemh("sprites.mem", sprite_rom, 8, 55);

  // whole pipeline holds while stage 2 waits on a full FIFO
  assign go = !(s2_valid && full);
  assign push = s2_valid && !full;
  assign job_done = push && s2_end;
  assign at_end = (u == SQ_MAX) && (v == SQ_MAX);
  assign at_border = (u == '0) || (v == '0) || (u == SQ_MAX) || (v == SQ_MAX);

  always_ff @(posedge clk) begin
    if (job_start) begin
      j_col <= job_col;
      j_row <= job_row;
      j_code <= job_code;
      j_box <= job_box;
      j_last <= job_last;
    end
  end

  // stage 0, walk u then v across the square
  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      u <= '0;
      v <= '0;
    end else if (job_start) begin
      active <= 1'b1;
      u <= '0;
      v <= '0;
    end else if (go && active) begin
      if (at_end) begin
        active <= 1'b0;
        u <= '0;
        v <= '0;
      end else if (u == SQ_MAX) begin
        u <= '0;
        v <= v + 1'b1;
      end else begin
        u <= u + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (go) begin
      // box mode drops the inner pixels
      s1_valid <= active && (!j_box || at_border);
      s2_valid <= s1_valid;
    end
  end

  // stage 1 reads the sprite row, stage 2 forms the pixel
  always_ff @(posedge clk) begin
    if (go) begin
      s1_u <= u[SQ_W-1:0];
      s1_v <= v[SQ_W-1:0];
      s1_end <= at_end;
      s1_bits <= sprite_rom[{j_code.f.kind, v[SQ_W-1:SCALE_LOG2]}];
      push_x <= COORD_W'({j_col, s1_u});
      push_y <= COORD_W'({j_row, s1_v});
      push_colour <= colour_next;
      s2_end <= s1_end;
      push_last <= s1_end && j_last;
    end
  end

  always_comb begin
    sq_colour = (j_col[0] ^ j_row[0]) ? COL_DARK : COL_LIGHT;
    is_piece = (j_code.f.kind != KIND_EMPTY) && (j_code.f.kind != KIND_RESERVED);
    // bit 7 is the leftmost pixel of a sprite row
    sprite_on = s1_bits[3'd7 - s1_u[SQ_W-1:SCALE_LOG2]];
    if (j_box) begin
      colour_next = COL_BOX;
    end else if (is_piece && sprite_on) begin
      colour_next = j_code.f.black ? COL_BLACK : COL_WHITE;
    end else begin
      colour_next = sq_colour;
    end
  end

  a_uv_range: assert property (@(posedge clk) disable iff (reset)
    u <= SQ_MAX && v <= SQ_MAX);

endmodule

/* run.sh */
#!/bin/sh
# build and run from the project root, sprites.mem is read from here
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --assert -Wno-fatal --top-module tb_chess_view -f filelist.f \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_chess_view)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

/* sprites.mem */
// sprite rows for kinds 1 to 6, eight rows each from top to bottom
// one hex byte per row, bit 7 is the leftmost pixel
// pawn
00
00
18
3C
18
3C
7E
00
// knight
00
1C
3E
76
0E
1C
3E
7E
// bishop
00
18
24
3C
18
3C
7E
00
// rook
00
5A
7E
3C
3C
3C
7E
00
// queen
00
5A
24
3C
18
3C
7E
00
// king
18
3C
18
3C
3C
3C
7E
00

/* verification/tb_chess_view.sv */
`timescale 1ns/1ns

module tb_chess_view;
  import chess_view_pkg::*;

  localparam int SCALE_LOG2 = 0;
  localparam int BLINK_FRAMES = 2;
  localparam int SQ = 8 << SCALE_LOG2;
  localparam int BOARD_PIX = 8 * SQ;
  localparam int NUM_FRAMES = 4;
  // 4 frames of about 8500 cycles at 50% ready, roughly 3x margin
  localparam int TIMEOUT_CYCLES = 100000;

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  logic [7:0]          paddr = 8'd0;
  logic                psel = 1'b0;
  logic                penable = 1'b0;
  logic                pwrite = 1'b0;
  logic [31:0]         pwdata = 32'd0;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic                pix_valid;
  logic                pix_ready = 1'b0;
  logic [COORD_W-1:0]  pix_x;
  logic [COORD_W-1:0]  pix_y;
  logic [COLOUR_W-1:0] pix_colour;
  logic                frame_done;

  // testbench copy of the board and the sprites
  logic [3:0]          board_exp [64];
  logic [7:0]          sprite_bits [0:47];
  int                  box_col;
  int                  box_row;

  // frame-buffer model
  logic [2:0]          fb_colour [BOARD_PIX][BOARD_PIX];
  int                  fb_count [BOARD_PIX][BOARD_PIX];
  int                  pix_total;
  int                  frames_seen;
  logic                frame_pending;
  logic                stall_seen;
  logic [COORD_W-1:0]  held_x;
  logic [COORD_W-1:0]  held_y;
  logic [COLOUR_W-1:0] held_colour;
  int                  cycles;

  chess_view_top #(.SCALE_LOG2(SCALE_LOG2), .BLINK_FRAMES(BLINK_FRAMES)) i_dut (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .pix_valid, .pix_ready, .pix_x, .pix_y, .pix_colour, .frame_done
  );

  always #2 clk = ~clk;

  // frame buffer accepts about half the time
  always @(negedge clk) begin
    pix_ready = reset ? 1'b0 : 1'($urandom_range(0, 1));
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, frames seen %0d", cycles, frames_seen));
    end
  end

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    paddr = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    assert (pready) else abort_run("pready low during an APB write access");
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err = pslverr;
    assert (pready) else abort_run("pready low during an APB read access");
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  function automatic logic [31:0] row_word(input int r);
    logic [31:0] w;
    w = '0;
    for (int c = 0; c < 8; c++) begin
      w[4*c +: 4] = board_exp[r*8 + c];
    end
    return w;
  endfunction

  // phase for the frame in progress, from frames finished so far
  function automatic logic blink_expected();
    return ((frames_seen / BLINK_FRAMES) % 2) == 1;
  endfunction

  function automatic logic on_box_border(input int x, input int y);
    int u;
    int v;
    u = x % SQ;
    v = y % SQ;
    return (x / SQ == box_col) && (y / SQ == box_row) &&
           (u == 0 || v == 0 || u == SQ - 1 || v == SQ - 1);
  endfunction

  function automatic logic [2:0] pixel_ref(input int x, input int y);
    int c;
    int r;
    int kind;
    logic [3:0] code;
    logic [7:0] bits;
    logic [2:0] colour;
    c = x / SQ;
    r = y / SQ;
    code = board_exp[r*8 + c];
    kind = int'(code[2:0]);
    colour = ((c + r) % 2 == 0) ? COL_LIGHT : COL_DARK;
    if (kind >= 1 && kind <= 6) begin
      bits = sprite_bits[(kind - 1) * 8 + ((y % SQ) >> SCALE_LOG2)];
      if (bits[7 - ((x % SQ) >> SCALE_LOG2)]) begin
        colour = code[3] ? COL_BLACK : COL_WHITE;
      end
    end
    if (blink_expected() && on_box_border(x, y)) begin
      colour = COL_BOX;
    end
    return colour;
  endfunction

  // records transfers, watches stalls, compares on frame_done
  always @(posedge clk) begin : monitor
    int x;
    int y;
    logic [2:0] exp;
    if (!reset) begin
      if (stall_seen) begin
        assert (pix_valid && pix_x == held_x && pix_y == held_y && pix_colour == held_colour)
          else abort_run("Pixel port changed while stalled");
      end
      stall_seen = pix_valid && !pix_ready;
      held_x = pix_x;
      held_y = pix_y;
      held_colour = pix_colour;
      if (pix_valid && pix_ready) begin
        assert (frame_pending) else abort_run("Pixel transfer with no frame pending");
        assert (pix_x < BOARD_PIX && pix_y < BOARD_PIX)
          else abort_run($sformatf("Pixel (%0d, %0d) outside the board", pix_x, pix_y));
        x = int'(pix_x);
        y = int'(pix_y);
        if (fb_count[x][y] != 0) begin
          assert (blink_expected() && on_box_border(x, y))
            else abort_run($sformatf("Pixel (%0d, %0d) written twice in a non-box square", x, y));
        end
        fb_colour[x][y] = pix_colour;
        fb_count[x][y] = fb_count[x][y] + 1;
        pix_total = pix_total + 1;
      end
      if (frame_done) begin
        assert (frame_pending) else abort_run("frame_done without a pending frame");
        assert (pix_total == BOARD_PIX * BOARD_PIX + (blink_expected() ? 4 * SQ - 4 : 0))
          else abort_run($sformatf("Error at %0t: pixel count of frame %0d expected %0d actual %0d",
                                   $time, frames_seen + 1,
                                   BOARD_PIX * BOARD_PIX + (blink_expected() ? 4 * SQ - 4 : 0),
                                   pix_total));
        for (x = 0; x < BOARD_PIX; x++) begin
          for (y = 0; y < BOARD_PIX; y++) begin
            assert (fb_count[x][y] != 0)
              else abort_run($sformatf("Pixel (%0d, %0d) not written before frame_done", x, y));
            exp = pixel_ref(x, y);
            assert (fb_colour[x][y] == exp)
              else abort_run($sformatf("Error at %0t: pix_colour at (%0d, %0d) expected %0d actual %0d",
                                       $time, x, y, exp, fb_colour[x][y]));
            fb_count[x][y] = 0;
          end
        end
        pix_total = 0;
        frame_pending = 1'b0;
        frames_seen = frames_seen + 1;
      end
    end
  end

  // every code once, then random fill, then shuffled
  task automatic build_board();
    int j;
    logic [3:0] tmp;
    for (int i = 0; i < 64; i++) begin
      board_exp[i] = (i < 16) ? 4'(i) : 4'($urandom_range(0, 15));
    end
    for (int i = 63; i > 0; i--) begin
      j = int'($urandom_range(0, i));
      tmp = board_exp[i];
      board_exp[i] = board_exp[j];
      board_exp[j] = tmp;
    end
  endtask

  initial begin : main
    logic [31:0] rd;
    logic err;
    logic [31:0] exp_word;
    void'($urandom(85));
    pix_total = 0;
    frames_seen = 0;
    frame_pending = 1'b0;
    stall_seen = 1'b0;
    cycles = 0;
    for (int x = 0; x < BOARD_PIX; x++) begin
      for (int y = 0; y < BOARD_PIX; y++) begin
        fb_count[x][y] = 0;
      end
    end
    $readmemh("sprites.mem", sprite_bits);
    repeat (5) @(negedge clk);
    reset = 1'b0;

    build_board();
    box_col = int'($urandom_range(0, 7));
    box_row = int'($urandom_range(0, 7));
    for (int r = 0; r < 8; r++) begin
      apb_write(REG_ROW0 + 8'(4 * r), row_word(r));
    end
    apb_write(REG_BOX, 32'((box_row << 4) | box_col));

    // register read-back
    for (int r = 0; r < 9; r++) begin
      exp_word = (r < 8) ? row_word(r) : 32'((box_row << 4) | box_col);
      apb_read(8'(4 * r), rd, err);
      assert (!err)
        else abort_run($sformatf("pslverr raised for the valid offset 0x%02h", 4 * r));
      assert (rd == exp_word)
        else abort_run($sformatf("Error at %0t: prdata at 0x%02h expected 0x%08h actual 0x%08h",
                                 $time, 4 * r, exp_word, rd));
    end
    apb_read(REG_STATUS + 8'd4, rd, err);
    assert (err) else abort_run("No pslverr for an offset above REG_STATUS");

    for (int f = 1; f <= NUM_FRAMES; f++) begin
      frame_pending = 1'b1;
      apb_write(REG_CTRL, 32'd1);
      repeat (50) @(negedge clk);
      apb_read(REG_STATUS, rd, err);
      assert (rd[0]) else abort_run("Status shows idle in the middle of a frame");
      // second start while busy gives no extra frame
      apb_write(REG_CTRL, 32'd1);
      while (frames_seen < f) @(negedge clk);
      repeat (20) @(negedge clk);
      apb_read(REG_STATUS, rd, err);
      assert (!rd[0]) else abort_run("Status still busy after frame_done");
      assert (rd[15:8] == 8'(f))
        else abort_run($sformatf("Error at %0t: frame_count expected %0d actual %0d",
                                 $time, f, rd[15:8]));
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
